/* isaPkg.sv */
package isaPkg;

    localparam int dataW    = 16;   // datapath and register width
    localparam int instrW   = 16;   // one instruction word
    localparam int regAddrW = 3;    // r0..r7
    localparam int opW      = 5;    // opcode sits in instr[15:11]
    localparam int memAddrW = 4;    // sixteen data words

    // opcodes that retire with a result
    localparam logic [opW-1:0] opAddi   = 5'b01000;
    localparam logic [opW-1:0] opSubi   = 5'b01001;
    localparam logic [opW-1:0] opXori   = 5'b01010;
    localparam logic [opW-1:0] opAndni  = 5'b01011;
    localparam logic [opW-1:0] opSt     = 5'b10000;
    localparam logic [opW-1:0] opLd     = 5'b10001;
    localparam logic [opW-1:0] opRArith = 5'b11011; // add sub xor andn by fn

    // decoded for forwarding only, these retire as no-ops
    localparam logic [opW-1:0] opJr     = 5'b00101;
    localparam logic [opW-1:0] opJalr   = 5'b00111;
    localparam logic [opW-1:0] opBeqz   = 5'b01100;
    localparam logic [opW-1:0] opBnez   = 5'b01101;
    localparam logic [opW-1:0] opBltz   = 5'b01110;
    localparam logic [opW-1:0] opBgez   = 5'b01111;
    localparam logic [opW-1:0] opSlbi   = 5'b10010;
    localparam logic [opW-1:0] opStu    = 5'b10011;
    localparam logic [opW-1:0] opRoli   = 5'b10100;
    localparam logic [opW-1:0] opSlli   = 5'b10101;
    localparam logic [opW-1:0] opRori   = 5'b10110;
    localparam logic [opW-1:0] opSrli   = 5'b10111;
    localparam logic [opW-1:0] opBtr    = 5'b11001;
    localparam logic [opW-1:0] opRShift = 5'b11010;
    localparam logic [opW-1:0] opSeq    = 5'b11100;
    localparam logic [opW-1:0] opSlt    = 5'b11101;
    localparam logic [opW-1:0] opSle    = 5'b11110;
    localparam logic [opW-1:0] opSco    = 5'b11111;

    // r-format arithmetic group, instr[1:0]
    localparam logic [1:0] fnAdd  = 2'b00;
    localparam logic [1:0] fnSub  = 2'b01;  // rt - rs
    localparam logic [1:0] fnXor  = 2'b10;
    localparam logic [1:0] fnAndn = 2'b11;  // rs & ~rt

    // i-format reads rs only, its rt field is an immediate or rd
    function automatic logic isIFormat(input logic [opW-1:0] op);
        return op inside {opBeqz, opBnez, opBltz, opBgez, opSlbi, opJr, opJalr,
                          opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori,
                          opSrli, opStu, opSt, opLd, opBtr};
    endfunction

    function automatic logic isRFormat(input logic [opW-1:0] op);
        return op inside {opRArith, opRShift, opSeq, opSlt, opSle, opSco};
    endfunction

    // rt is a real source for r-format and for the store data register
    function automatic logic usesRt(input logic [opW-1:0] op);
        return isRFormat(op) | (op == opSt) | (op == opStu);
    endfunction

endpackage

/* pipePkg.sv */
package pipePkg;
    import isaPkg::*;

    localparam int cntW = 16;   // stall counter width

    typedef struct packed {
        logic [instrW-1:0] instr;
    } ifIdT;

    typedef struct packed {
        logic [opW-1:0]      opcode;
        logic [1:0]          fn;
        logic [regAddrW-1:0] rs;
        logic [regAddrW-1:0] rt;       // also the st data register
        logic [regAddrW-1:0] rd;
        logic [dataW-1:0]    imm;      // sign-extended instr[4:0]
        logic [dataW-1:0]    rsVal;
        logic [dataW-1:0]    rtVal;
        logic                regWrite;
        logic                memWrite;
        logic                memRead;
    } idExT;

    typedef struct packed {
        logic [dataW-1:0]    aluResult;  // also the ld/st address
        logic [dataW-1:0]    storeData;
        logic [regAddrW-1:0] rd;
        logic                regWrite;
        logic                memWrite;
        logic                memRead;
    } exMemT;

    typedef struct packed {
        logic [dataW-1:0]    wrData;
        logic [regAddrW-1:0] rd;
        logic                regWrite;
    } memWbT;

endpackage

/* pipeReg.sv */
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,      // keep current content
    input  logic    flush,     // load a bubble, wins over hold
    input  payloadT d,
    input  logic    validIn,
    output payloadT q,
    output logic    validOut
);

    // bubbles always carry an all-zero payload so their control bits are off
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q        <= '0;
            validOut <= 1'b0;
        end else if (flush) begin
            q        <= '0;
            validOut <= 1'b0;
        end else if (!hold) begin
            q        <= validIn ? d : '0;
            validOut <= validIn;
        end
    end

endmodule

/* forwardingUnit.sv */
`timescale 1ns/1ns

module forwardingUnit
    import isaPkg::*;
(
    input  logic                regWriteExMem,
    input  logic                regWriteMemWb,
    input  logic [regAddrW-1:0] registerRdExMem,
    input  logic [regAddrW-1:0] registerRdMemWb,
    input  logic [regAddrW-1:0] registerRsIdEx,
    input  logic [regAddrW-1:0] registerRtIdEx,
    input  logic [regAddrW-1:0] registerRsIfId,
    input  logic [regAddrW-1:0] registerRtIfId,
    input  logic                memWriteExMem,
    input  logic [opW-1:0]      opcodeIdEx,
    input  logic [opW-1:0]      opcodeIfId,
    output logic [1:0]          forwardA,      // 10 ex-ex, 01 mem-ex, 00 regfile
    output logic [1:0]          forwardB,
    output logic                forwardAMemId, // regfile write-through select
    output logic                forwardBMemId
);

    logic iFmtIdEx, rFmtIdEx;
    logic iFmtIfId, rFmtIfId;
    logic rtUsedIdEx;
    logic exMemWr;
    logic fwdAExEx, fwdAMemEx;
    logic fwdBExEx, fwdBMemEx;

    assign iFmtIdEx   = isIFormat(opcodeIdEx);
    assign rFmtIdEx   = isRFormat(opcodeIdEx);
    assign iFmtIfId   = isIFormat(opcodeIfId);
    assign rFmtIfId   = isRFormat(opcodeIfId);
    assign rtUsedIdEx = usesRt(opcodeIdEx);   // i-format b side is the immediate

    // a store in ex/mem never produces a register result
    assign exMemWr = regWriteExMem & ~memWriteExMem;

    // operand a, r0 matches like any other register
    assign fwdAExEx  = exMemWr & (rFmtIdEx | iFmtIdEx)
                     & (registerRdExMem == registerRsIdEx);
    assign fwdAMemEx = regWriteMemWb & (rFmtIdEx | iFmtIdEx)
                     & ~fwdAExEx                          // newer result wins
                     & (registerRdMemWb == registerRsIdEx);

    // operand b, only where rt is a register source
    assign fwdBExEx  = exMemWr & rtUsedIdEx
                     & (registerRdExMem == registerRtIdEx);
    assign fwdBMemEx = regWriteMemWb & rtUsedIdEx
                     & ~fwdBExEx
                     & (registerRdMemWb == registerRtIdEx);

    assign forwardA = fwdAExEx  ? 2'b10 :
                      fwdAMemEx ? 2'b01 :
                                  2'b00;
    assign forwardB = fwdBExEx  ? 2'b10 :
                      fwdBMemEx ? 2'b01 :
                                  2'b00;

    // decode reads the register that mem/wb writes this cycle
    // only the if/id fields matter here, the id/ex instruction already has its operands
    assign forwardAMemId = regWriteMemWb & (rFmtIfId | iFmtIfId)
                         & (registerRdMemWb == registerRsIfId);
    assign forwardBMemId = regWriteMemWb & (rFmtIfId | iFmtIfId)
                         & (registerRdMemWb == registerRtIfId);

endmodule

/* stallCtrl.sv */
`timescale 1ns/1ns

module stallCtrl
    import isaPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                memReadIdEx,     // ld in id/ex
    input  logic [regAddrW-1:0] registerRdIdEx,
    input  logic [regAddrW-1:0] registerRsIfId,
    input  logic [regAddrW-1:0] registerRtIfId,
    input  logic [opW-1:0]      opcodeIfId,
    output logic                stall            // hold if/id, bubble into id/ex
);

    typedef enum logic {
        sRun,
        sBubble
    } stateT;

    stateT state;
    logic  rsUsed, rtUsed;
    logic  loadUse;

    assign rsUsed = isIFormat(opcodeIfId) | isRFormat(opcodeIfId);
    assign rtUsed = usesRt(opcodeIfId);

    assign loadUse = memReadIdEx
                   & ((rsUsed & (registerRsIfId == registerRdIdEx))
                    | (rtUsed & (registerRtIfId == registerRdIdEx)));

    // mealy output, the ld moves on while the user waits one cycle
    assign stall = (state == sRun) & loadUse;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sRun;
        end else begin
            case (state)
                sRun:    if (loadUse) state <= sBubble;
                sBubble: state <= sRun;   // bubble now sits in id/ex
                default: state <= sRun;
            endcase
        end
    end

endmodule

/* stallCounter.sv */
`timescale 1ns/1ns

module stallCounter
    import pipePkg::*;
(
    input  logic            clk,
    input  logic            rstN,
    input  logic            stall,
    output logic [cntW-1:0] stallCount
);

    logic atMax;

    assign atMax = &stallCount;   // sticks at all ones

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stallCount <= '0;
        end else if (stall && !atMax) begin
            stallCount <= stallCount + 1'b1;   // edge closing the stall cycle
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ns

module regFile
    import isaPkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic [regAddrW-1:0] rdAddrA,
    input  logic [regAddrW-1:0] rdAddrB,
    input  logic                forwardAMemId,
    input  logic                forwardBMemId,
    input  logic                wrEn,
    input  logic [regAddrW-1:0] wrAddr,
    input  logic [dataW-1:0]    wrData,
    output logic [dataW-1:0]    rdDataA,
    output logic [dataW-1:0]    rdDataB
);

    logic [dataW-1:0] regs [0:(2**regAddrW)-1];   // r0 is writable

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**regAddrW; i++) regs[i] <= '0;
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // write-through so decode sees the value landing at this edge
    assign rdDataA = forwardAMemId ? wrData : regs[rdAddrA];
    assign rdDataB = forwardBMemId ? wrData : regs[rdAddrB];

endmodule

/* execUnit.sv */
`timescale 1ns/1ns

module execUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             rstN,
    input  idExT             idEx,
    input  logic [1:0]       forwardA,
    input  logic [1:0]       forwardB,
    input  logic [dataW-1:0] exMemResult,     // ex-ex source
    input  logic [dataW-1:0] memWbData,       // mem-ex source
    input  logic [dataW-1:0] memAddrExMem,    // ex/mem alu result
    input  logic [dataW-1:0] storeDataExMem,
    input  logic             memWriteExMem,
    output logic [dataW-1:0] aluResult,
    output logic [dataW-1:0] storeData,
    output logic [dataW-1:0] loadData
);

    logic [dataW-1:0] opA, rtVal, opB;
    logic [1:0]       aluOp;
    logic [dataW-1:0] dmem [0:(2**memAddrW)-1];

    always_comb begin
        case (forwardA)
            2'b10:   opA = exMemResult;
            2'b01:   opA = memWbData;
            default: opA = idEx.rsVal;
        endcase
        case (forwardB)
            2'b10:   rtVal = exMemResult;
            2'b01:   rtVal = memWbData;
            default: rtVal = idEx.rtVal;
        endcase
    end

    assign opB       = (idEx.opcode == opRArith) ? rtVal : idEx.imm;
    assign storeData = rtVal;   // st data keeps the forwarded rt

    always_comb begin
        case (idEx.opcode)
            opRArith: aluOp = idEx.fn;
            opSubi:   aluOp = fnSub;
            opXori:   aluOp = fnXor;
            opAndni:  aluOp = fnAndn;
            default:  aluOp = fnAdd;   // addi, ld and st address
        endcase
        case (aluOp)
            fnSub:   aluResult = opB - opA;   // wisc subtracts rs from b
            fnXor:   aluResult = opA ^ opB;
            fnAndn:  aluResult = opA & ~opB;
            default: aluResult = opA + opB;
        endcase
    end

    // data memory sits in the ex/mem stage, low address bits index it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 2**memAddrW; i++) dmem[i] <= '0;
        end else if (memWriteExMem) begin
            dmem[memAddrExMem[memAddrW-1:0]] <= storeDataExMem;
        end
    end

    assign loadData = dmem[memAddrExMem[memAddrW-1:0]];   // same-cycle read

endmodule

/* fwdPipeTop.sv */
`timescale 1ns/1ns

module fwdPipeTop
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                instrValid,
    input  logic [instrW-1:0]   instr,
    output logic                stall,
    output logic                wbEn,
    output logic [regAddrW-1:0] wbReg,
    output logic [dataW-1:0]    wbData,
    output logic [cntW-1:0]     stallCount
);

    ifIdT  ifIdIn, ifId;
    idExT  idExIn, idEx;
    exMemT exMemIn, exMem;
    memWbT memWbIn, memWb;
    logic  ifIdValid, idExValid, exMemValid, memWbValid;

    logic [1:0]          forwardA, forwardB;
    logic                forwardAMemId, forwardBMemId;
    logic [dataW-1:0]    rsVal, rtVal;
    logic [dataW-1:0]    aluResult, storeData, loadData;
    logic [opW-1:0]      opIfId;
    logic [regAddrW-1:0] rsIfId, rtIfId;

    assign ifIdIn.instr = instr;
    assign opIfId = ifId.instr[15:11];
    assign rsIfId = ifId.instr[10:8];
    assign rtIfId = ifId.instr[7:5];

    // decode, rd moves to [4:2] for r-format
    always_comb begin
        idExIn.opcode   = opIfId;
        idExIn.fn       = ifId.instr[1:0];
        idExIn.rs       = rsIfId;
        idExIn.rt       = rtIfId;
        idExIn.rd       = isRFormat(opIfId) ? ifId.instr[4:2] : rtIfId;
        idExIn.imm      = {{(dataW-5){ifId.instr[4]}}, ifId.instr[4:0]};
        idExIn.rsVal    = rsVal;
        idExIn.rtVal    = rtVal;
        idExIn.regWrite = opIfId inside {opRArith, opAddi, opSubi, opXori, opAndni, opLd};
        idExIn.memWrite = (opIfId == opSt);
        idExIn.memRead  = (opIfId == opLd);
    end

    always_comb begin
        exMemIn.aluResult = aluResult;
        exMemIn.storeData = storeData;
        exMemIn.rd        = idEx.rd;
        exMemIn.regWrite  = idEx.regWrite;
        exMemIn.memWrite  = idEx.memWrite;
        exMemIn.memRead   = idEx.memRead;
        memWbIn.wrData    = exMem.memRead ? loadData : exMem.aluResult;   // wb select
        memWbIn.rd        = exMem.rd;
        memWbIn.regWrite  = exMem.regWrite;
    end

    assign wbEn   = memWbValid & memWb.regWrite;
    assign wbReg  = memWb.rd;
    assign wbData = memWb.wrData;

    pipeReg #(.payloadT(ifIdT)) ifIdReg (.clk, .rstN, .hold(stall), .flush(1'b0),
        .d(ifIdIn), .validIn(instrValid), .q(ifId), .validOut(ifIdValid));
    pipeReg #(.payloadT(idExT)) idExReg (.clk, .rstN, .hold(1'b0), .flush(stall),
        .d(idExIn), .validIn(ifIdValid), .q(idEx), .validOut(idExValid));
    pipeReg #(.payloadT(exMemT)) exMemReg (.clk, .rstN, .hold(1'b0), .flush(1'b0),
        .d(exMemIn), .validIn(idExValid), .q(exMem), .validOut(exMemValid));
    pipeReg #(.payloadT(memWbT)) memWbReg (.clk, .rstN, .hold(1'b0), .flush(1'b0),
        .d(memWbIn), .validIn(exMemValid), .q(memWb), .validOut(memWbValid));

    forwardingUnit fwd0 (.regWriteExMem(exMem.regWrite), .regWriteMemWb(memWb.regWrite),
        .registerRdExMem(exMem.rd), .registerRdMemWb(memWb.rd),
        .registerRsIdEx(idEx.rs), .registerRtIdEx(idEx.rt),
        .registerRsIfId(rsIfId), .registerRtIfId(rtIfId),
        .memWriteExMem(exMem.memWrite), .opcodeIdEx(idEx.opcode), .opcodeIfId(opIfId),
        .forwardA, .forwardB, .forwardAMemId, .forwardBMemId);

    stallCtrl stall0 (.clk, .rstN, .memReadIdEx(idEx.memRead), .registerRdIdEx(idEx.rd),
        .registerRsIfId(rsIfId), .registerRtIfId(rtIfId), .opcodeIfId(opIfId), .stall);

    stallCounter cnt0 (.clk, .rstN, .stall, .stallCount);

    regFile rf0 (.clk, .rstN, .rdAddrA(rsIfId), .rdAddrB(rtIfId),
        .forwardAMemId, .forwardBMemId, .wrEn(wbEn), .wrAddr(memWb.rd),
        .wrData(memWb.wrData), .rdDataA(rsVal), .rdDataB(rtVal));

    execUnit ex0 (.clk, .rstN, .idEx, .forwardA, .forwardB,
        .exMemResult(exMem.aluResult), .memWbData(memWb.wrData),
        .memAddrExMem(exMem.aluResult), .storeDataExMem(exMem.storeData),
        .memWriteExMem(exMem.memWrite), .aluResult, .storeData, .loadData);

endmodule

/* fwdPipe_chk.sv */
`timescale 1ns/1ns

module fwdPipeChk
    import pipePkg::*;
(
    input logic            clk,
    input logic            rstN,
    input logic            stall,
    input logic            wbEn,
    input logic [cntW-1:0] stallCount
);

    // a load-use bubble lasts one cycle
    noDoubleStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !stall)
        else $error("stall stayed high for two consecutive cycles");

    countOnStall: assert property (@(posedge clk) disable iff (!rstN)
        stall && !(&stallCount) |=> stallCount == $past(stallCount) + cntW'(1))
        else $error("stall counter missed a stall cycle");

    countHeld: assert property (@(posedge clk) disable iff (!rstN)
        !stall |=> $stable(stallCount))   // count frozen without a stall
        else $error("stall counter moved without a stall");

    quietInReset: assert property (@(posedge clk)
        !rstN |-> !wbEn && !stall && stallCount == '0)
        else $error("pipeline outputs active during reset");

    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN) |=> !wbEn && !stall && stallCount == '0)   // first running cycle
        else $error("pipeline outputs active right after reset");

endmodule

bind fwdPipeTop fwdPipeChk chk0 (.clk, .rstN, .stall, .wbEn, .stallCount);

/* fwdPipeTb.sv */
`timescale 1ns/1ns

module fwdPipeTb
    import isaPkg::*;
    import pipePkg::*;
();

    localparam int clkPeriod   = 4;
    localparam int resetCycles = 16;
    localparam int progLen     = 400;   // instructions taken before draining

    logic                clk;
    logic                rstN;
    logic                instrValid;
    logic [instrW-1:0]   instr;
    logic                stall;
    logic                wbEn;
    logic [regAddrW-1:0] wbReg;
    logic [dataW-1:0]    wbData;
    logic [cntW-1:0]     stallCount;

    // architectural model updated in program order as instructions are taken
    logic [dataW-1:0]    regModel [0:(2**regAddrW)-1];
    logic [dataW-1:0]    memModel [0:(2**memAddrW)-1];
    logic [regAddrW-1:0] expReg [$];
    logic [dataW-1:0]    expData [$];

    logic [31:0]         lcgState;
    logic [instrW-1:0]   curInstr;   // word currently on the instr port
    logic                ifIdLd;     // if/id occupant is a ld
    logic [regAddrW-1:0] ifIdRd;
    logic                expStall;   // predicted stall for the current cycle
    logic                willTake;
    logic                held;
    int taken, wbExpected, wbSeen, stallsPredicted, idle;
    int dataErrors, regErrors, stallErrors, otherErrors;

    fwdPipeTop dut0 (
        .clk, .rstN, .instrValid, .instr,
        .stall, .wbEn, .wbReg, .wbData, .stallCount
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // two cycles per instruction covers every stall and bubble, plus reset and drain
    initial begin
        #(clkPeriod * (progLen * 2 + 100));
        $display("timeout: the pipeline did not retire the program in time");
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 12 of 16 codes land on r0..r2 to crowd hazards together
    function automatic logic [regAddrW-1:0] pickReg(input logic [3:0] n);
        if (n < 4'd12) return 3'(n % 4'd3);
        return n[2:0];
    endfunction

    function automatic logic [instrW-1:0] makeInstr(input logic [31:0] r);
        logic [opW-1:0] op;
        case (r[19:17])
            3'd0:    op = opAddi;
            3'd1:    op = opSubi;
            3'd2:    op = opXori;
            3'd3:    op = opAndni;
            3'd4:    op = opLd;
            3'd5:    op = opSt;
            default: op = opRArith;   // two slots of eight
        endcase
        if (op == opRArith) return {op, pickReg(r[31:28]), pickReg(r[27:24]),
                                    pickReg(r[23:20]), r[16:15]};
        return {op, pickReg(r[31:28]), pickReg(r[27:24]), r[14:10]};
    endfunction

    // rs is a source of every generated op, rt only for r-format and st
    function automatic logic readsReg(input logic [instrW-1:0] w,
                                      input logic [regAddrW-1:0] r);
        logic rtIsSrc;
        rtIsSrc = (w[15:11] == opRArith) || (w[15:11] == opSt);
        return (w[10:8] == r) || (rtIsSrc && (w[7:5] == r));
    endfunction

    task automatic driveNext();
        lcgState = lcgNext(lcgState);
        instrValid <= (lcgState[31:29] != 3'd0);   // one bubble in eight
        lcgState = lcgNext(lcgState);
        curInstr = makeInstr(lcgState);
        instr <= curInstr;
    endtask

    task automatic retire(input logic [instrW-1:0] w);
        logic [regAddrW-1:0] dst;
        logic [dataW-1:0]    a, b, imm, addr, res;
        logic                writes;
        a      = regModel[w[10:8]];
        b      = regModel[w[7:5]];
        imm    = {{(dataW-5){w[4]}}, w[4:0]};
        addr   = a + imm;
        dst    = w[7:5];   // i-format destination
        writes = 1'b1;
        res    = '0;
        case (w[15:11])
            opRArith: begin
                dst = w[4:2];
                case (w[1:0])
                    fnAdd:   res = a + b;
                    fnSub:   res = b - a;   // rt minus rs
                    fnXor:   res = a ^ b;
                    default: res = a & ~b;
                endcase
            end
            opAddi:  res = a + imm;
            opSubi:  res = imm - a;
            opXori:  res = a ^ imm;
            opAndni: res = a & ~imm;
            opLd:    res = memModel[addr[memAddrW-1:0]];
            opSt: begin
                memModel[addr[memAddrW-1:0]] = b;
                writes = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes) begin
            regModel[dst] = res;
            expReg.push_back(dst);
            expData.push_back(res);
            wbExpected++;
        end
    endtask

    // runs just after the edge with take and held sampled at the negedge before it
    task automatic stepModel(input logic take, input logic wasHeld);
        if (take) begin
            expStall = ifIdLd && readsReg(curInstr, ifIdRd);   // ld now in id/ex
            if (expStall) stallsPredicted++;
            ifIdLd = (curInstr[15:11] == opLd);
            ifIdRd = curInstr[7:5];
            retire(curInstr);
            taken++;
            if (taken < progLen) driveNext();
            else instrValid <= 1'b0;
        end else begin
            expStall = 1'b0;
            if (!wasHeld) begin
                ifIdLd = 1'b0;   // a bubble entered if/id
                driveNext();
            end
        end
    endtask

    task automatic checkOutputs();
        assert (stall == expStall) else begin
            stallErrors++;
            $display("mismatch stall: got %h expected %h", stall, expStall);
        end
        if (wbEn) begin
            assert (expData.size() != 0) else begin
                otherErrors++;
                $display("writeback to r%0d arrived with no instruction left to retire", wbReg);
            end
            if (expData.size() != 0) begin
                assert (wbReg == expReg[0]) else begin
                    regErrors++;
                    $display("mismatch wbReg: got %h expected %h", wbReg, expReg[0]);
                end
                assert (wbData == expData[0]) else begin
                    dataErrors++;
                    $display("mismatch wbData: got %h expected %h", wbData, expData[0]);
                end
                void'(expReg.pop_front());
                void'(expData.pop_front());
            end
            wbSeen++;   // every writeback counts, stray ones too
        end
    endtask

    initial begin
        rstN       <= 1'b0;
        instrValid <= 1'b0;
        instr      <= '0;
        lcgState = 32'hf0d7;
        curInstr = '0;
        ifIdLd   = 1'b0;
        ifIdRd   = '0;
        expStall = 1'b0;
        willTake = 1'b0;
        held     = 1'b0;
        taken = 0;
        wbExpected = 0;
        wbSeen = 0;
        stallsPredicted = 0;
        idle = 0;
        dataErrors = 0;
        regErrors = 0;
        stallErrors = 0;
        otherErrors = 0;
        for (int i = 0; i < 2**regAddrW; i++) regModel[i] = '0;
        for (int i = 0; i < 2**memAddrW; i++) memModel[i] = '0;

        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        driveNext();

        while (taken < progLen) begin
            @(negedge clk);
            checkOutputs();
            willTake = instrValid && !stall;
            held     = stall;   // source keeps the same word
            @(posedge clk);
            stepModel(willTake, held);
        end

        // drain the queue and idle a few cycles to catch stray writebacks
        while (expData.size() != 0 || idle < 4) begin
            @(negedge clk);
            checkOutputs();
            @(posedge clk);
            expStall = 1'b0;
            if (expData.size() == 0) idle++;
        end

        @(negedge clk);
        assert (stallCount == cntW'(stallsPredicted)) else begin
            otherErrors++;
            $display("mismatch stallCount: got %h expected %h",
                     stallCount, cntW'(stallsPredicted));
        end
        assert (wbSeen == wbExpected) else begin
            otherErrors++;
            $display("saw %0d writebacks but %0d register-writing instructions were taken",
                     wbSeen, wbExpected);
        end

        $display("errors: wbData %0d, wbReg %0d, stall %0d, other %0d",
                 dataErrors, regErrors, stallErrors, otherErrors);
        if (dataErrors + regErrors + stallErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sim.f */
isaPkg.sv
pipePkg.sv
pipeReg.sv
forwardingUnit.sv
stallCtrl.sv
stallCounter.sv
regFile.sv
execUnit.sv
fwdPipeTop.sv
fwdPipe_chk.sv
fwdPipeTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module fwdPipeTb -o fwdPipeSim

output=$(./obj_dir/fwdPipeSim 2>&1) || true
echo "$output"

if grep -qx "All tests passed!" <<< "$output"; then
    exit 0
fi
exit 1
